//--- compile.f
+incdir+src
src/simd_lane_pkg.sv
src/simd_tag_pkg.sv
src/simd_input_stage.sv
src/result_fifo.sv
src/upstream_sender.sv
src/simd_wrapper.sv
verif/simd_wrapper_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f compile.f --top-module simd_wrapper_tb \
  -o simd_wrapper_sim &&
  ./obj_dir/simd_wrapper_sim | tee /dev/stderr | grep -q "all tests passed" &&
  echo "PASS" || { echo "FAIL"; exit 1; }

//--- verif/simd_wrapper_tb.sv
`timescale 1ns/1ns
`include "simd_wrapper_settings.svh"

module simd_wrapper_tb;

  import simd_lane_pkg::*;
  import simd_tag_pkg::*;

  localparam int LANES   = `SIMD_NUM_LANES;
  localparam int TIMEOUT = 500;

  // One expected upstream burst
  typedef struct packed {
    tag_t                    tag;
    num_lanes_t              num_lanes;
    lane_mask_t              mask;
    lane_entry_t [LANES-1:0] lanes;
  } burst_t;

  logic       clk = 1'b0;
  logic       rst;
  lane_data_t cntl_rs0;
  lane_data_t cntl_rs1;
  lane_data_t scntl_rs0;
  lane_data_t scntl_rs1;
  logic       tag_valid;
  tag_t       tag;
  num_lanes_t tag_num_lanes;
  logic       tag_ready;
  lane_mask_t reg_valid;
  lane_cntl_t reg_cntl [LANES];
  lane_data_t reg_data [LANES];
  lane_mask_t reg_ready;
  tag_t       sui_tag;
  num_lanes_t sui_tag_num_lanes;
  lane_mask_t sui_regs_valid;
  lane_cntl_t sui_regs_cntl [LANES];
  lane_data_t sui_regs      [LANES];
  logic       sui_regs_ready;
  logic       sui_regs_complete = 1'b0;

  // Model of everything handed to the DUT and not yet sent upstream
  tag_entry_t  tag_q  [$];
  lane_entry_t lane_q [LANES][$];

  logic [31:0] rng_state     = 32'd25991;
  string       test_name     = "reset";
  int          burst_count   = 0;
  lane_mask_t  last_mask     = '0;
  logic        hold_complete = 1'b0;
  int          rise_wait     = 0;
  int          fall_wait     = 0;

  simd_wrapper dut_i (.*);

  always #4 clk = ~clk;

  // --------------------
  // Helpers

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    stop_with_error($sformatf("ERROR %s: %s expected %0h actual %0h",
                              test_name, what, expected, actual));
  endtask

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Oldest tag joined with the head result of each lane it covers
  function automatic burst_t expected_burst();
    burst_t b;
    b           = '0;
    b.tag       = tag_q[0].tag;
    b.num_lanes = tag_q[0].num_lanes;
    for (int i = 0; i < LANES; i++)
    begin
      if (i < int'(b.num_lanes))
      begin
        b.mask[i]  = 1'b1;
        b.lanes[i] = lane_q[i][0];
      end
    end
    return b;
  endfunction

  task automatic send_tag(input tag_t t, input num_lanes_t n);
    int cycles;
    cycles = 0;
    while (!tag_ready)
    begin
      assert (cycles < TIMEOUT) else stop_with_error("Timeout waiting for tag_ready");
      @(posedge clk);
      #1;
      cycles++;
    end
    tag_valid     = 1'b1;
    tag           = t;
    tag_num_lanes = n;
    tag_q.push_back({n, t});
    @(posedge clk);
    #1;
    tag_valid = 1'b0;
  endtask

  // Lanes outside the count get random data with valid low
  task automatic write_results(input num_lanes_t n);
    lane_mask_t mask;
    int         cycles;
    mask   = lane_mask_t'((1 << n) - 1);
    cycles = 0;
    while ((reg_ready & mask) != mask)
    begin
      assert (cycles < TIMEOUT) else stop_with_error("Timeout waiting for reg_ready");
      @(posedge clk);
      #1;
      cycles++;
    end
    for (int i = 0; i < LANES; i++)
    begin
      reg_cntl[i] = lane_cntl_t'(xorshift());
      reg_data[i] = xorshift();
      if (mask[i])
      begin
        lane_q[i].push_back({reg_cntl[i], reg_data[i]});
      end
    end
    reg_valid = mask;
    @(posedge clk);
    #1;
    reg_valid = '0;
  endtask

  task automatic wait_bursts(input int target);
    int cycles;
    cycles = 0;
    while (burst_count < target)
    begin
      assert (cycles < TIMEOUT)
        else stop_with_error($sformatf("Timeout waiting for burst %0d", target));
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  // --------------------
  // Compare each burst against the model

  task automatic check_burst();
    burst_t exp;
    assert (tag_q.size() > 0) else stop_with_error("Burst sent with no tag outstanding");
    for (int i = 0; i < int'(tag_q[0].num_lanes); i++)
    begin
      assert (lane_q[i].size() > 0)
        else stop_with_error($sformatf("Burst covers lane %0d with no result written", i));
    end
    exp = expected_burst();
    assert (sui_tag == exp.tag) else report_mismatch("tag", 64'(exp.tag), 64'(sui_tag));
    assert (sui_tag_num_lanes == exp.num_lanes)
      else report_mismatch("num_lanes", 64'(exp.num_lanes), 64'(sui_tag_num_lanes));
    assert (sui_regs_valid == exp.mask)
      else report_mismatch("valid mask", 64'(exp.mask), 64'(sui_regs_valid));
    for (int i = 0; i < LANES; i++)
    begin
      assert (sui_regs_cntl[i] == exp.lanes[i].cntl)
        else report_mismatch($sformatf("lane %0d cntl", i), 64'(exp.lanes[i].cntl),
                             64'(sui_regs_cntl[i]));
      assert (sui_regs[i] == exp.lanes[i].data)
        else report_mismatch($sformatf("lane %0d data", i), 64'(exp.lanes[i].data),
                             64'(sui_regs[i]));
      if (exp.mask[i])
      begin
        void'(lane_q[i].pop_front());
      end
    end
    void'(tag_q.pop_front());
    last_mask = sui_regs_valid;
    burst_count++;
  endtask

  always @(negedge clk)
  begin
    if (!rst && sui_regs_valid != '0)
    begin
      check_burst();
    end
  end

  // Upstream side raises complete after each pulse and drops it later
  always @(posedge clk)
  begin
    #1;
    if (sui_regs_valid != '0)
    begin
      rise_wait = 2 + burst_count % 3;
    end
    else if (rise_wait > 0)
    begin
      rise_wait--;
      if (rise_wait == 0)
      begin
        sui_regs_complete = 1'b1;
        fall_wait         = 1 + burst_count % 4;
      end
    end
    else if (fall_wait > 0 && !hold_complete)
    begin
      fall_wait--;
      if (fall_wait == 0)
      begin
        sui_regs_complete = 1'b0;
      end
    end
  end

  // --------------------
  // Stimulus

  initial
  begin
    int          cycles;
    int          base;
    int          leftover;
    logic [31:0] r;
    num_lanes_t  n;
    lane_data_t  rs0;
    lane_data_t  rs1;
    lane_data_t  prev0;
    lane_data_t  prev1;

    rst            = 1'b1;
    cntl_rs0       = '0;
    cntl_rs1       = '0;
    tag_valid      = 1'b0;
    tag            = '0;
    tag_num_lanes  = '0;
    reg_valid      = '0;
    sui_regs_ready = 1'b1;
    for (int i = 0; i < LANES; i++)
    begin
      reg_cntl[i] = '0;
      reg_data[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    assert (sui_regs_valid == '0 && sui_tag == '0 && sui_tag_num_lanes == '0)
      else stop_with_error("Upstream tag or valid not zero after reset");
    for (int i = 0; i < LANES; i++)
    begin
      assert (sui_regs[i] == '0 && sui_regs_cntl[i] == '0)
        else stop_with_error($sformatf("Upstream lane %0d not zero after reset", i));
    end
    cycles = 0;
    while (!tag_ready)
    begin
      assert (cycles < 2) else stop_with_error("tag_ready not high within two cycles of reset");
      @(posedge clk);
      #1;
      cycles++;
    end

    // Config registers lag by exactly one cycle
    test_name = "config";
    prev0     = '0;
    prev1     = '0;
    for (int k = 0; k < 6; k++)
    begin
      rs0      = xorshift();
      rs1      = xorshift();
      cntl_rs0 = rs0;
      cntl_rs1 = rs1;
      @(negedge clk);
      assert (scntl_rs0 == prev0)
        else report_mismatch("scntl_rs0 early", 64'(prev0), 64'(scntl_rs0));
      assert (scntl_rs1 == prev1)
        else report_mismatch("scntl_rs1 early", 64'(prev1), 64'(scntl_rs1));
      @(posedge clk);
      #1;
      assert (scntl_rs0 == rs0) else report_mismatch("scntl_rs0", 64'(rs0), 64'(scntl_rs0));
      assert (scntl_rs1 == rs1) else report_mismatch("scntl_rs1", 64'(rs1), 64'(scntl_rs1));
      prev0 = rs0;
      prev1 = rs1;
    end

    // Results land before or after their tag
    test_name = "random stream";
    base      = burst_count;
    for (int k = 0; k < 40; k++)
    begin
      r = xorshift();
      n = num_lanes_t'(1 + r % 4);
      if (r[8])
      begin
        write_results(n);
        send_tag(tag_t'(k), n);
      end
      else
      begin
        send_tag(tag_t'(k), n);
        repeat (r[5:4])
        begin
          @(posedge clk);
          #1;
        end
        write_results(n);
      end
    end
    wait_bursts(base + 40);

    // Lane 3 still holds data from the random stream
    test_name = "single burst";
    base      = burst_count;
    send_tag(8'hA5, 3'd3);
    write_results(3'd3);
    wait_bursts(base + 1);
    assert (last_mask == 4'b0111) else report_mismatch("valid mask", 64'h7, 64'(last_mask));
    assert (sui_tag == 8'hA5) else report_mismatch("tag", 64'hA5, 64'(sui_tag));
    assert (sui_tag_num_lanes == 3'd3)
      else report_mismatch("num_lanes", 64'd3, 64'(sui_tag_num_lanes));
    assert (sui_regs[3] == '0 && sui_regs_cntl[3] == '0)
      else stop_with_error("Lane 3 not zero in a three lane burst");

    test_name      = "back-pressure";
    base           = burst_count;
    sui_regs_ready = 1'b0;
    send_tag(8'hB0, 3'd4);
    send_tag(8'hB1, 3'd4);
    cycles = 0;
    while (tag_ready)
    begin
      assert (cycles < 4) else stop_with_error("tag_ready stayed high past the tag threshold");
      @(posedge clk);
      #1;
      cycles++;
    end
    for (int k = 0; k < 6; k++)
    begin
      assert (reg_ready == 4'hF)
        else report_mismatch("reg_ready before write", 64'hF, 64'(reg_ready));
      write_results(3'd4);
    end
    assert (reg_ready == 4'h0)
      else report_mismatch("reg_ready after six writes", 64'h0, 64'(reg_ready));
    repeat (16) @(posedge clk);
    #1;
    assert (burst_count == base) else stop_with_error("Burst sent while sui_regs_ready was low");
    sui_regs_ready = 1'b1;
    for (int k = 0; k < 4; k++)
    begin
      send_tag(tag_t'(8'hB2 + k), 3'd4);
    end
    wait_bursts(base + 6);

    // Second burst is ready but must wait for complete to fall
    test_name = "completion";
    base      = burst_count;
    send_tag(8'hC0, 3'd2);
    write_results(3'd2);
    send_tag(8'hC1, 3'd1);
    write_results(3'd1);
    wait_bursts(base + 1);
    hold_complete = 1'b1;
    cycles = 0;
    while (!sui_regs_complete)
    begin
      assert (cycles < 20) else stop_with_error("Responder never raised complete");
      @(posedge clk);
      #1;
      cycles++;
    end
    repeat (16) @(posedge clk);
    #1;
    assert (burst_count == base + 1) else stop_with_error("Burst sent while complete was high");
    hold_complete = 1'b0;
    cycles = 0;
    while (sui_regs_complete)
    begin
      assert (cycles < 20) else stop_with_error("Responder never dropped complete");
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (burst_count == base + 1) else stop_with_error("Burst sent before complete fell");
    wait_bursts(base + 2);

    leftover = tag_q.size();
    for (int i = 0; i < LANES; i++)
    begin
      leftover += lane_q[i].size();
    end
    if (leftover == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      stop_with_error($sformatf("%0d tags or results never sent upstream", leftover));
    end
  end

endmodule

//--- src/simd_wrapper.sv
`timescale 1ns/1ns
`include "simd_wrapper_settings.svh"

module simd_wrapper (
  input  logic                        clk,
  input  logic                        rst,

  // Scalar configuration in and out
  input  simd_lane_pkg::lane_data_t   cntl_rs0,
  input  simd_lane_pkg::lane_data_t   cntl_rs1,
  output simd_lane_pkg::lane_data_t   scntl_rs0,
  output simd_lane_pkg::lane_data_t   scntl_rs1,

  // Tags from the PE controller
  input  logic                        tag_valid,
  input  simd_tag_pkg::tag_t          tag,
  input  simd_tag_pkg::num_lanes_t    tag_num_lanes,
  output logic                        tag_ready,

  // Lane results from the stream operations
  input  simd_lane_pkg::lane_mask_t   reg_valid,
  input  simd_lane_pkg::lane_cntl_t   reg_cntl [`SIMD_NUM_LANES],
  input  simd_lane_pkg::lane_data_t   reg_data [`SIMD_NUM_LANES],
  output simd_lane_pkg::lane_mask_t   reg_ready,

  // Stack upstream side
  output simd_tag_pkg::tag_t          sui_tag,
  output simd_tag_pkg::num_lanes_t    sui_tag_num_lanes,
  output simd_lane_pkg::lane_mask_t   sui_regs_valid,
  output simd_lane_pkg::lane_cntl_t   sui_regs_cntl [`SIMD_NUM_LANES],
  output simd_lane_pkg::lane_data_t   sui_regs      [`SIMD_NUM_LANES],
  input  logic                        sui_regs_ready,
  input  logic                        sui_regs_complete
);

  import simd_lane_pkg::*;
  import simd_tag_pkg::*;

  logic        tag_write;
  tag_entry_t  tag_write_entry;
  logic        regs_ready_d1;
  logic        regs_complete_d1;

  logic        tag_pipe_valid;
  tag_entry_t  tag_pipe_entry;
  logic        tag_pipe_read;
  logic        tag_almost_full;

  lane_mask_t  lane_pipe_valid;
  lane_entry_t lane_pipe_entry [`SIMD_NUM_LANES];
  lane_mask_t  lane_pipe_read;
  lane_mask_t  lane_almost_full;

  simd_input_stage input_stage_i (
    .clk               (clk),
    .rst               (rst),
    .tag_valid         (tag_valid),
    .tag               (tag),
    .tag_num_lanes     (tag_num_lanes),
    .sui_regs_ready    (sui_regs_ready),
    .sui_regs_complete (sui_regs_complete),
    .cntl_rs0          (cntl_rs0),
    .cntl_rs1          (cntl_rs1),
    .tag_write         (tag_write),
    .tag_write_entry   (tag_write_entry),
    .regs_ready_d1     (regs_ready_d1),
    .regs_complete_d1  (regs_complete_d1),
    .scntl_rs0         (scntl_rs0),
    .scntl_rs1         (scntl_rs1)
  );

  // --------------------
  // Lane result FIFOs

  for (genvar i = 0; i < `SIMD_NUM_LANES; i++)
  begin : g_lane_fifo
    lane_entry_t write_entry;

    // Results are written without a register stage
    assign write_entry.cntl = reg_cntl[i];
    assign write_entry.data = reg_data[i];

    result_fifo #(
      .payload_t (lane_entry_t),
      .DEPTH     (`SIMD_LANE_FIFO_DEPTH),
      .THRESHOLD (`SIMD_LANE_FIFO_THRESHOLD)
    ) fifo_i (
      .clk         (clk),
      .rst         (rst),
      .write       (reg_valid[i]),
      .write_data  (write_entry),
      .almost_full (lane_almost_full[i]),
      .pipe_valid  (lane_pipe_valid[i]),
      .pipe_data   (lane_pipe_entry[i]),
      .pipe_read   (lane_pipe_read[i])
    );
  end

  assign reg_ready = ~lane_almost_full;

  // --------------------
  // Tag FIFO

  result_fifo #(
    .payload_t (tag_entry_t),
    .DEPTH     (`SIMD_TAG_FIFO_DEPTH),
    .THRESHOLD (`SIMD_TAG_FIFO_THRESHOLD)
  ) tag_fifo_i (
    .clk         (clk),
    .rst         (rst),
    .write       (tag_write),
    .write_data  (tag_write_entry),
    .almost_full (tag_almost_full),
    .pipe_valid  (tag_pipe_valid),
    .pipe_data   (tag_pipe_entry),
    .pipe_read   (tag_pipe_read)
  );

  // Low during reset and the cycle after
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag_ready <= 1'b0;
    end
    else
    begin
      tag_ready <= ~tag_almost_full;
    end
  end

  upstream_sender sender_i (
    .clk               (clk),
    .rst               (rst),
    .tag_pipe_valid    (tag_pipe_valid),
    .tag_pipe_entry    (tag_pipe_entry),
    .tag_pipe_read     (tag_pipe_read),
    .lane_pipe_valid   (lane_pipe_valid),
    .lane_pipe_entry   (lane_pipe_entry),
    .lane_pipe_read    (lane_pipe_read),
    .regs_ready_d1     (regs_ready_d1),
    .regs_complete_d1  (regs_complete_d1),
    .sui_tag           (sui_tag),
    .sui_tag_num_lanes (sui_tag_num_lanes),
    .sui_regs_valid    (sui_regs_valid),
    .sui_regs_cntl     (sui_regs_cntl),
    .sui_regs          (sui_regs)
  );

endmodule

//--- src/upstream_sender.sv
`timescale 1ns/1ns
`include "simd_wrapper_settings.svh"

module upstream_sender (
  input  logic                        clk,
  input  logic                        rst,

  // Tag FIFO head
  input  logic                        tag_pipe_valid,
  input  simd_tag_pkg::tag_entry_t    tag_pipe_entry,
  output logic                        tag_pipe_read,

  // Lane FIFO heads
  input  simd_lane_pkg::lane_mask_t   lane_pipe_valid,
  input  simd_lane_pkg::lane_entry_t  lane_pipe_entry [`SIMD_NUM_LANES],
  output simd_lane_pkg::lane_mask_t   lane_pipe_read,

  // Registered upstream status
  input  logic                        regs_ready_d1,
  input  logic                        regs_complete_d1,

  // Burst toward the stack upstream side
  output simd_tag_pkg::tag_t          sui_tag,
  output simd_tag_pkg::num_lanes_t    sui_tag_num_lanes,
  output simd_lane_pkg::lane_mask_t   sui_regs_valid,
  output simd_lane_pkg::lane_cntl_t   sui_regs_cntl [`SIMD_NUM_LANES],
  output simd_lane_pkg::lane_data_t   sui_regs      [`SIMD_NUM_LANES]
);

  import simd_lane_pkg::*;
  import simd_tag_pkg::*;

  upstream_state_t state;
  upstream_state_t state_next;
  lane_mask_t      active_lanes;
  logic            lanes_ready;
  logic            send;

  // --------------------
  // Head decode

  // Lanes below the tag's count take part in the burst
  always_comb
  begin
    for (int i = 0; i < `SIMD_NUM_LANES; i++)
    begin
      active_lanes[i] = (i < int'(tag_pipe_entry.num_lanes));
    end
  end

  // Idle lanes need no result
  assign lanes_ready = &(lane_pipe_valid | ~active_lanes);

  // --------------------
  // State machine

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= WAIT;
    end
    else
    begin
      state <= state_next;
    end
  end

  always_comb
  begin
    case (state)
      WAIT:
        state_next = (tag_pipe_valid && lanes_ready && regs_ready_d1) ? SEND_DATA : WAIT;
      SEND_DATA:
        state_next = WAIT_FOR_COMPLETE;
      // Completion must rise and then fall
      WAIT_FOR_COMPLETE:
        state_next = regs_complete_d1 ? WAIT_COMPLETE_DEASSERTED : WAIT_FOR_COMPLETE;
      WAIT_COMPLETE_DEASSERTED:
        state_next = regs_complete_d1 ? WAIT_COMPLETE_DEASSERTED : COMPLETE;
      COMPLETE:
        state_next = WAIT;
      default:
        state_next = WAIT;
    endcase
  end

  assign send = (state == SEND_DATA);

  // Pop the tag and only the lanes it covers
  assign tag_pipe_read  = send;
  assign lane_pipe_read = {`SIMD_NUM_LANES{send}} & active_lanes;

  // --------------------
  // Registered burst

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sui_tag           <= '0;
      sui_tag_num_lanes <= '0;
      sui_regs_valid    <= '0;
      for (int i = 0; i < `SIMD_NUM_LANES; i++)
      begin
        sui_regs_cntl[i] <= '0;
        sui_regs[i]      <= '0;
      end
    end
    else
    begin
      // Valid is a single cycle pulse and the payload holds until the next send
      sui_regs_valid <= send ? active_lanes : '0;
      if (send)
      begin
        sui_tag           <= tag_pipe_entry.tag;
        sui_tag_num_lanes <= tag_pipe_entry.num_lanes;
        for (int i = 0; i < `SIMD_NUM_LANES; i++)
        begin
          sui_regs_cntl[i] <= active_lanes[i] ? lane_pipe_entry[i].cntl : '0;
          sui_regs[i]      <= active_lanes[i] ? lane_pipe_entry[i].data : '0;
        end
      end
    end
  end

endmodule

//--- src/result_fifo.sv
`timescale 1ns/1ns

module result_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4,
  parameter int  THRESHOLD = 2
) (
  input  logic     clk,
  input  logic     rst,

  // Write side
  input  logic     write,
  input  payload_t write_data,
  output logic     almost_full,

  // Head of the queue
  output logic     pipe_valid,
  output payload_t pipe_data,
  input  logic     pipe_read
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  typedef logic [PTR_WIDTH-1:0]   ptr_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  payload_t mem [DEPTH];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  count_t   count;
  logic     push;
  logic     pop;

  // Writes into a full buffer are dropped
  assign push = write && (count != count_t'(DEPTH));
  assign pop  = pipe_read && pipe_valid;

  assign pipe_valid  = (count != '0);
  assign pipe_data   = mem[rd_ptr];
  assign almost_full = (count >= count_t'(THRESHOLD));

  // --------------------
  // Storage

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= write_data;
    end
  end

  // --------------------
  // Pointers and occupancy

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/simd_input_stage.sv
`timescale 1ns/1ns

module simd_input_stage (
  input  logic                        clk,
  input  logic                        rst,

  // Tag from the PE controller
  input  logic                        tag_valid,
  input  simd_tag_pkg::tag_t          tag,
  input  simd_tag_pkg::num_lanes_t    tag_num_lanes,

  // Stack upstream status levels
  input  logic                        sui_regs_ready,
  input  logic                        sui_regs_complete,

  // Scalar configuration
  input  simd_lane_pkg::lane_data_t   cntl_rs0,
  input  simd_lane_pkg::lane_data_t   cntl_rs1,

  // Delayed tag write toward the tag FIFO
  output logic                        tag_write,
  output simd_tag_pkg::tag_entry_t    tag_write_entry,

  // Delayed status toward the sender
  output logic                        regs_ready_d1,
  output logic                        regs_complete_d1,

  // Configuration toward the stream-operation controller
  output simd_lane_pkg::lane_data_t   scntl_rs0,
  output simd_lane_pkg::lane_data_t   scntl_rs1
);

  // --------------------
  // Control side registers

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag_write                 <= 1'b0;
      tag_write_entry.tag       <= '0;
      tag_write_entry.num_lanes <= '0;
      regs_ready_d1             <= 1'b0;
      regs_complete_d1          <= 1'b0;
      scntl_rs0                 <= '0;
      scntl_rs1                 <= '0;
    end
    else
    begin
      // Tag and count land together in one FIFO entry
      tag_write                 <= tag_valid;
      tag_write_entry.tag       <= tag;
      tag_write_entry.num_lanes <= tag_num_lanes;
      regs_ready_d1             <= sui_regs_ready;
      regs_complete_d1          <= sui_regs_complete;
      scntl_rs0                 <= cntl_rs0;
      scntl_rs1                 <= cntl_rs1;
    end
  end

endmodule

//--- src/simd_tag_pkg.sv
`include "simd_wrapper_settings.svh"

package simd_tag_pkg;

  // Stack tag of one stream operation
  typedef logic [`SIMD_TAG_WIDTH-1:0] tag_t;

  // Active lane count from 0 up to the full lane count
  typedef logic [$clog2(`SIMD_NUM_LANES + 1)-1:0] num_lanes_t;

  // Payload of one tag FIFO entry
  typedef struct packed {
    num_lanes_t num_lanes;
    tag_t       tag;
  } tag_entry_t;

  // Upstream sender states
  typedef enum logic [2:0] {
    WAIT                     = 3'd0,
    SEND_DATA                = 3'd1,
    WAIT_FOR_COMPLETE        = 3'd2,
    WAIT_COMPLETE_DEASSERTED = 3'd3,
    COMPLETE                 = 3'd4
  } upstream_state_t;

endpackage

//--- src/simd_lane_pkg.sv
`include "simd_wrapper_settings.svh"

package simd_lane_pkg;

  // One lane's result word
  typedef logic [`SIMD_LANE_WIDTH-1:0] lane_data_t;

  // Stream marker that travels with each result
  typedef logic [`SIMD_CNTL_WIDTH-1:0] lane_cntl_t;

  // Payload of one lane FIFO entry
  typedef struct packed {
    lane_cntl_t cntl;
    lane_data_t data;
  } lane_entry_t;

  // One bit per execution lane
  typedef logic [`SIMD_NUM_LANES-1:0] lane_mask_t;

endpackage

//--- src/simd_wrapper_settings.svh
`ifndef SIMD_WRAPPER_SETTINGS_SVH
`define SIMD_WRAPPER_SETTINGS_SVH

// --------------------
// Lane geometry

`define SIMD_NUM_LANES   4
`define SIMD_LANE_WIDTH  32
// Start and end of stream markers
`define SIMD_CNTL_WIDTH  2
`define SIMD_TAG_WIDTH   8

// --------------------
// Buffering

`define SIMD_LANE_FIFO_DEPTH      8
`define SIMD_LANE_FIFO_THRESHOLD  6
`define SIMD_TAG_FIFO_DEPTH       4
`define SIMD_TAG_FIFO_THRESHOLD   2

`endif
